//--- source/motion_macros.svh
// motion subsystem constants for channel count, bus widths and register map
`ifndef MOTION_MACROS_SVH
`define MOTION_MACROS_SVH

// number of pwm channels hanging off the host bus
`define NOS_PWM_CHANNELS 2

// period, duty and counter width
`define PWM_WIDTH 16

// shared host data bus
`define UP_DATA_WIDTH 8

// register index inside one channel
`define REG_CONTROL 4'd0
`define REG_PERIOD  4'd1
`define REG_DUTY    4'd2

// half of one led blink at 50 MHz
`define HEARTBEAT_HALF_PERIOD_DEFAULT 25000000

`endif

//--- source/motion_bus_pkg.sv
// host bus types for bytes, register addresses, register data and protocol states
`default_nettype none

`include "motion_macros.svh"

package motion_bus_pkg;

   // one byte on the shared host bus
   typedef logic [`UP_DATA_WIDTH-1:0] up_byte_t;

   // upper nibble picks the channel and lower nibble the register
   typedef logic [`UP_DATA_WIDTH-1:0] reg_addr_t;

   // full register value
   // travels as two bytes with the low byte first
   typedef logic [`PWM_WIDTH-1:0] reg_data_t;

   // byte transfer protocol
   // ACKED waits for the address strobe
   // the BYTE states cover both data bytes
   typedef enum logic [2:0] {
      IDLE,
      ACKED,
      ADDR_WAIT_LOW,
      BYTE_WAIT_HIGH,
      BYTE_WAIT_LOW,
      FINISH
   } bus_state_t;

endpackage

`default_nettype wire

//--- source/pwm_pkg.sv
// pwm types for counts, register selection and channel control
`default_nettype none

`include "motion_macros.svh"

package pwm_pkg;

   // period, duty and running counter share one width
   typedef logic [`PWM_WIDTH-1:0] pwm_count_t;

   // register index within a channel
   // matches the low nibble of the address byte
   typedef logic [3:0] pwm_reg_sel_t;

   // only bit 0 of the control register exists
   // it is the channel enable
   typedef logic pwm_enable_t;

endpackage

`default_nettype wire

//--- source/up_bus_controller.sv
// host bus controller that syncs the strobes and moves address and data bytes to registers
`timescale 1ns/100ps
`default_nettype none

`include "motion_macros.svh"

module up_bus_controller (
   input  logic                                             CLOCK_50,
   input  logic                                             rst,
   input  logic                                             async_up_start,
   input  logic                                             async_up_handshake_1,
   input  logic                                             async_up_rw,
   output logic                                             up_ack,
   output logic                                             up_handshake_2,
   inout  wire  [`UP_DATA_WIDTH-1:0]                        up_data,
   output motion_bus_pkg::reg_addr_t                        reg_addr,
   output motion_bus_pkg::reg_data_t                        reg_wdata,
   output logic                                             reg_write,
   input  motion_bus_pkg::reg_data_t [`NOS_PWM_CHANNELS-1:0] reg_rdata
);
   import motion_bus_pkg::*;

   // two flop synchronizers per host level
   logic [1:0] start_sync;
   logic [1:0] hs1_sync;
   logic [1:0] rw_sync;
   logic       start_s;
   logic       hs1_s;
   logic       rw_s;

   bus_state_t state;
   // rw high means the host reads
   logic       read_mode;
   // 0 for the low data byte, 1 for the high one
   logic       byte_cnt;
   logic       bus_drive;
   logic       addr_take;
   logic       addr_done;
   logic       byte_take;
   reg_data_t  rd_snap;
   reg_data_t  rdata_any;
   up_byte_t   tx_byte;

   always_ff @(posedge CLOCK_50) begin
      if (rst) begin
         start_sync <= '0;
         hs1_sync   <= '0;
         rw_sync    <= '0;
      end else begin
         start_sync <= {start_sync[0], async_up_start};
         hs1_sync   <= {hs1_sync[0], async_up_handshake_1};
         rw_sync    <= {rw_sync[0], async_up_rw};
      end
   end

   assign start_s = start_sync[1];
   assign hs1_s   = hs1_sync[1];
   assign rw_s    = rw_sync[1];

   // unaddressed channels return zero so a plain OR selects
   always_comb begin
      rdata_any = '0;
      for (int i = 0; i < `NOS_PWM_CHANNELS; i++) begin
         rdata_any = rdata_any | reg_rdata[i];
      end
   end

   // address byte arrives on the first strobe after ack
   assign addr_take = (state == ACKED) && start_s && hs1_s;
   // host dropped the address strobe
   assign addr_done = (state == ADDR_WAIT_LOW) && !hs1_s;
   // on a read the byte must already sit on the bus before handshake_2
   assign byte_take = (state == BYTE_WAIT_HIGH) && hs1_s && (!read_mode || bus_drive);

   assign tx_byte = byte_cnt ? rd_snap[2*`UP_DATA_WIDTH-1:`UP_DATA_WIDTH]
                             : rd_snap[`UP_DATA_WIDTH-1:0];
   assign up_data = bus_drive ? tx_byte : 'z;

   always_ff @(posedge CLOCK_50) begin
      if (rst) begin
         state          <= IDLE;
         up_ack         <= 1'b0;
         up_handshake_2 <= 1'b0;
         reg_write      <= 1'b0;
         bus_drive      <= 1'b0;
         read_mode      <= 1'b0;
         byte_cnt       <= 1'b0;
      end else begin
         reg_write <= 1'b0;
         case (state)
            IDLE: begin
               if (start_s) begin
                  up_ack    <= 1'b1;
                  read_mode <= rw_s;
                  byte_cnt  <= 1'b0;
                  state     <= ACKED;
               end
            end
            ACKED: begin
               // start dropped before any byte so give up quietly
               if (!start_s) begin
                  up_ack <= 1'b0;
                  state  <= IDLE;
               end else if (addr_take) begin
                  up_handshake_2 <= 1'b1;
                  state          <= ADDR_WAIT_LOW;
               end
            end
            ADDR_WAIT_LOW: begin
               if (addr_done) begin
                  up_handshake_2 <= 1'b0;
                  // low read byte goes out right away
                  bus_drive      <= read_mode;
                  state          <= BYTE_WAIT_HIGH;
               end
            end
            BYTE_WAIT_HIGH: begin
               bus_drive <= read_mode;
               if (byte_take) begin
                  up_handshake_2 <= 1'b1;
                  // high byte of a write completes the register
                  reg_write      <= !read_mode && byte_cnt;
                  state          <= BYTE_WAIT_LOW;
               end
            end
            BYTE_WAIT_LOW: begin
               if (!hs1_s) begin
                  up_handshake_2 <= 1'b0;
                  bus_drive      <= 1'b0;
                  if (byte_cnt) begin
                     state <= FINISH;
                  end else begin
                     byte_cnt <= 1'b1;
                     state    <= BYTE_WAIT_HIGH;
                  end
               end
            end
            FINISH: begin
               if (!start_s) begin
                  up_ack <= 1'b0;
                  state  <= IDLE;
               end
            end
            default: state <= IDLE;
         endcase
      end
   end

   // address, write assembly and read snapshot
   always_ff @(posedge CLOCK_50) begin
      if (addr_take) begin
         reg_addr <= up_data;
      end
      // channels decode the held address combinationally
      if (addr_done) begin
         rd_snap <= rdata_any;
      end
      if (byte_take && !read_mode) begin
         if (byte_cnt) begin
            reg_wdata[2*`UP_DATA_WIDTH-1:`UP_DATA_WIDTH] <= up_data;
         end else begin
            reg_wdata[`UP_DATA_WIDTH-1:0] <= up_data;
         end
      end
   end

   a_hs2_inside_ack: assert property (@(posedge CLOCK_50) disable iff (rst)
      up_handshake_2 |-> up_ack)
      else $error("handshake_2 high without ack");

   a_drive_on_read: assert property (@(posedge CLOCK_50) disable iff (rst)
      bus_drive |-> (up_ack && read_mode))
      else $error("host bus driven outside a read");

   a_write_single: assert property (@(posedge CLOCK_50) disable iff (rst)
      reg_write |=> !reg_write)
      else $error("reg_write held for two cycles");

endmodule

`default_nettype wire

//--- source/pwm_generator.sv
// pwm period counter with wrap-loaded shadow registers and a registered compare
`timescale 1ns/100ps
`default_nettype none

module pwm_generator (
   input  logic                CLOCK_50,
   input  logic                rst,
   input  logic                enable,
   input  pwm_pkg::pwm_count_t period,
   input  pwm_pkg::pwm_count_t duty,
   output logic                pwm_signal
);
   import pwm_pkg::*;

   pwm_count_t count;
   pwm_count_t shadow_period;
   pwm_count_t shadow_duty;
   // enable from the last cycle
   logic       enable_q;
   logic       wrap;

   // zero period wraps every cycle and keeps count at 0
   assign wrap = (shadow_period == '0) || (count == shadow_period - pwm_count_t'(1));

   always_ff @(posedge CLOCK_50) begin
      if (rst) begin
         count         <= '0;
         shadow_period <= '0;
         shadow_duty   <= '0;
         enable_q      <= 1'b0;
         pwm_signal    <= 1'b0;
      end else begin
         enable_q <= enable;
         // compare runs on the current count so output trails it by one cycle
         pwm_signal <= enable && enable_q && (shadow_period != '0) && (count < shadow_duty);
         if (!enable) begin
            count <= '0;
         end else if (!enable_q || wrap) begin
            // fresh enable or end of period picks up new values
            shadow_period <= period;
            shadow_duty   <= duty;
            count         <= '0;
         end else begin
            count <= count + pwm_count_t'(1);
         end
      end
   end

   a_count_in_period: assert property (@(posedge CLOCK_50) disable iff (rst)
      (shadow_period != '0) |-> (count < shadow_period))
      else $error("pwm counter ran past its period");

endmodule

`default_nettype wire

//--- source/pwm_channel.sv
// one pwm channel with its register bank, address decode and generator
`timescale 1ns/100ps
`default_nettype none

`include "motion_macros.svh"

module pwm_channel #(
   parameter int channel_index = 0
) (
   input  logic                      CLOCK_50,
   input  logic                      rst,
   input  motion_bus_pkg::reg_addr_t reg_addr,
   input  motion_bus_pkg::reg_data_t reg_wdata,
   input  logic                      reg_write,
   output motion_bus_pkg::reg_data_t reg_rdata,
   output logic                      pwm_signal
);
   import motion_bus_pkg::*;
   import pwm_pkg::*;

   localparam logic [3:0] chan_id = 4'(channel_index);

   logic         addr_hit;
   pwm_reg_sel_t reg_sel;
   pwm_enable_t  enable;
   pwm_count_t   period;
   pwm_count_t   duty;
   reg_data_t    ctrl_word;

   // channel in the upper nibble, register in the lower
   assign addr_hit = (reg_addr[7:4] == chan_id);
   assign reg_sel  = reg_addr[3:0];

   always_ff @(posedge CLOCK_50) begin
      if (rst) begin
         enable <= 1'b0;
         period <= '0;
         duty   <= '0;
      end else if (reg_write && addr_hit) begin
         case (reg_sel)
            `REG_CONTROL: enable <= reg_wdata[0];
            `REG_PERIOD:  period <= reg_wdata;
            `REG_DUTY:    duty   <= reg_wdata;
            // unmapped index
            default: ;
         endcase
      end
   end

   // upper control bits read as zero
   assign ctrl_word = {{(`PWM_WIDTH-1){1'b0}}, enable};

   always_comb begin
      reg_rdata = '0;
      if (addr_hit) begin
         case (reg_sel)
            `REG_CONTROL: reg_rdata = ctrl_word;
            `REG_PERIOD:  reg_rdata = period;
            `REG_DUTY:    reg_rdata = duty;
            default:      reg_rdata = '0;
         endcase
      end
   end

   pwm_generator pwm_gen (
      .CLOCK_50   (CLOCK_50),
      .rst        (rst),
      .enable     (enable),
      .period     (period),
      .duty       (duty),
      .pwm_signal (pwm_signal)
   );

endmodule

`default_nettype wire

//--- source/heartbeat_blinker.sv
// heartbeat divider that toggles the alive led every half period
`timescale 1ns/100ps
`default_nettype none

`include "motion_macros.svh"

module heartbeat_blinker #(
   parameter int unsigned half_period = `HEARTBEAT_HALF_PERIOD_DEFAULT
) (
   input  logic CLOCK_50,
   input  logic rst,
   output logic led
);
   localparam int cnt_width = (half_period > 1) ? $clog2(half_period) : 1;

   logic [cnt_width-1:0] div_cnt;

   // counts 0 to half_period-1 then flips led
   always_ff @(posedge CLOCK_50) begin
      if (rst) begin
         div_cnt <= '0;
         led     <= 1'b0;
      end else if (div_cnt == cnt_width'(half_period - 1)) begin
         div_cnt <= '0;
         led     <= ~led;
      end else begin
         div_cnt <= div_cnt + 1'b1;
      end
   end

endmodule

`default_nettype wire

//--- source/motion_system.sv
// motor drive top level joining the host bus controller, pwm channels and heartbeat
`timescale 1ns/100ps
`default_nettype none

`include "motion_macros.svh"

module motion_system #(
   parameter int unsigned heartbeat_half_period = `HEARTBEAT_HALF_PERIOD_DEFAULT
) (
   input  logic                         CLOCK_50,
   input  logic                         rst,
   input  logic                         async_up_start,
   input  logic                         async_up_handshake_1,
   input  logic                         async_up_rw,
   output logic                         up_ack,
   output logic                         up_handshake_2,
   inout  wire  [`UP_DATA_WIDTH-1:0]    up_data,
   output logic [`NOS_PWM_CHANNELS-1:0] pwm_out,
   output logic                         led1,
   output logic                         led2
);
   import motion_bus_pkg::*;

   // register bus from the controller to every channel
   reg_addr_t                        reg_addr;
   reg_data_t                        reg_wdata;
   logic                             reg_write;
   // one read slot per channel
   reg_data_t [`NOS_PWM_CHANNELS-1:0] reg_rdata;

   // reset indicator
   assign led2 = ~rst;

   heartbeat_blinker #(
      .half_period (heartbeat_half_period)
   ) alive (
      .CLOCK_50 (CLOCK_50),
      .rst      (rst),
      .led      (led1)
   );

   up_bus_controller up_ctrl (
      .CLOCK_50             (CLOCK_50),
      .rst                  (rst),
      .async_up_start       (async_up_start),
      .async_up_handshake_1 (async_up_handshake_1),
      .async_up_rw          (async_up_rw),
      .up_ack               (up_ack),
      .up_handshake_2       (up_handshake_2),
      .up_data              (up_data),
      .reg_addr             (reg_addr),
      .reg_wdata            (reg_wdata),
      .reg_write            (reg_write),
      .reg_rdata            (reg_rdata)
   );

   // channel number doubles as the address nibble
   for (genvar i = 0; i < `NOS_PWM_CHANNELS; i++) begin : g_pwm
      pwm_channel #(
         .channel_index (i)
      ) pwm_ch (
         .CLOCK_50   (CLOCK_50),
         .rst        (rst),
         .reg_addr   (reg_addr),
         .reg_wdata  (reg_wdata),
         .reg_write  (reg_write),
         .reg_rdata  (reg_rdata[i]),
         .pwm_signal (pwm_out[i])
      );
   end

endmodule

`default_nettype wire

//--- tests/motion_system_tb.sv
// testbench for the motor drive top level with a host bus model, pwm measurement and heartbeat
`timescale 1ns/100ps
`default_nettype none

`include "motion_macros.svh"

module motion_system_tb;
   import motion_bus_pkg::*;
   import pwm_pkg::*;

   localparam int hb_half = 64;
   // cycles allowed for one handshake edge
   localparam int wait_limit = 100;
   // ~70 transactions under 40 cycles, waveform runs under 300 cycles
   // and 8 heartbeat half periods all fit far inside this
   localparam int timeout_cycles = 60000;
   localparam logic [31:0] lfsr_seed = 32'hc7fd_27c2;
   localparam logic [31:0] lfsr_taps = 32'h8020_0003;
   localparam reg_addr_t unmapped [4] = '{8'h50, 8'h51, 8'h07, 8'h17};

   logic                         clk;
   logic                         rst;
   logic                         start;
   logic                         hs1;
   logic                         rw;
   logic                         ack;
   logic                         hs2;
   wire  [`UP_DATA_WIDTH-1:0]    up_data;
   logic [`NOS_PWM_CHANNELS-1:0] pwm_out;
   logic                         led1;
   logic                         led2;
   logic                         host_drive;
   up_byte_t                     host_byte;
   logic [31:0]                  lfsr;
   logic                         hb_done;
   int                           errors = 0;
   int                           timeouts = 0;
   int                           cycles = 0;
   // expected register contents per channel
   reg_data_t                    model [`NOS_PWM_CHANNELS][3];

   // host side of the shared bus
   assign up_data = host_drive ? host_byte : 'z;

   motion_system #(
      .heartbeat_half_period (hb_half)
   ) motion_system_i (
      .CLOCK_50             (clk),
      .rst                  (rst),
      .async_up_start       (start),
      .async_up_handshake_1 (hs1),
      .async_up_rw          (rw),
      .up_ack               (ack),
      .up_handshake_2       (hs2),
      .up_data              (up_data),
      .pwm_out              (pwm_out),
      .led1                 (led1),
      .led2                 (led2)
   );

   initial begin
      clk = 1'b0;
      forever #4 clk = ~clk;
   end

   always @(posedge clk) begin
      cycles <= cycles + 1;
      if (cycles >= timeout_cycles) begin
         $display("run stopped after %0d cycles before all tests finished", cycles);
         $display("TEST FAILED");
         $finish;
      end
   end

   // galois step with feedback when the bit shifted out is set
   function automatic logic [31:0] lfsr_step(input logic [31:0] s);
      return s[0] ? ((s >> 1) ^ lfsr_taps) : (s >> 1);
   endfunction

   // one lfsr step per bit taken
   function automatic int unsigned rand_bits(input int n);
      int unsigned v;
      v = 0;
      for (int i = 0; i < n; i++) begin
         lfsr = lfsr_step(lfsr);
         v = (v << 1) | lfsr[0];
      end
      return v;
   endfunction

   // high cycles in the upper half, low cycles in the lower half
   function automatic logic [31:0] expected_high_low(input pwm_count_t period,
                                                     input pwm_count_t duty,
                                                     input logic enable);
      pwm_count_t high;
      if (!enable || period == 0) begin
         return {16'd0, period};
      end
      high = (duty >= period) ? period : duty;
      return {high, period - high};
   endfunction

   function automatic reg_addr_t reg_address(input int ch, input int r);
      return {4'(ch), 4'(r)};
   endfunction

   task automatic check_value(input string name, input logic [31:0] expected,
                              input logic [31:0] actual);
      if (expected !== actual) begin
         errors++;
         $display("MISMATCH %s expected %0h actual %0h", name, expected, actual);
      end
   endtask

   // polls ack or handshake_2 on falling edges
   task automatic wait_for(input logic on_hs2, input logic level, input string what);
      int n;
      n = 0;
      while (((on_hs2 ? hs2 : ack) !== level) && (n < wait_limit)) begin
         @(negedge clk);
         n++;
      end
      if (n >= wait_limit) begin
         timeouts++;
         $display("host waited %0d cycles and %s never arrived", wait_limit, what);
      end
   endtask

   task automatic host_start(input logic read);
      rw    = read;
      start = 1'b1;
      wait_for(1'b0, 1'b1, "ack rise");
   endtask

   task automatic host_end();
      start = 1'b0;
      rw    = 1'b0;
      wait_for(1'b0, 1'b0, "ack fall");
   endtask

   // four phase byte where the host drives only when writing
   task automatic host_byte_xfer(input logic drive, input up_byte_t tx, output up_byte_t rx);
      host_byte  = tx;
      host_drive = drive;
      hs1        = 1'b1;
      wait_for(1'b1, 1'b1, "handshake_2 rise");
      rx         = up_data;
      hs1        = 1'b0;
      host_drive = 1'b0;
      wait_for(1'b1, 1'b0, "handshake_2 fall");
   endtask

   task automatic host_write(input reg_addr_t addr, input reg_data_t data);
      up_byte_t rx;
      host_start(1'b0);
      host_byte_xfer(1'b1, addr, rx);
      host_byte_xfer(1'b1, data[7:0], rx);
      host_byte_xfer(1'b1, data[15:8], rx);
      host_end();
   endtask

   task automatic host_read(input reg_addr_t addr, output reg_data_t data);
      up_byte_t lo;
      up_byte_t hi;
      host_start(1'b1);
      host_byte_xfer(1'b1, addr, lo);
      host_byte_xfer(1'b0, 8'h00, lo);
      host_byte_xfer(1'b0, 8'h00, hi);
      host_end();
      data = {hi, lo};
   endtask

   // only the enable bit of control survives
   task automatic write_reg(input int ch, input int r, input reg_data_t value);
      host_write(reg_address(ch, r), value);
      model[ch][r] = (r == `REG_CONTROL) ? (value & 16'h0001) : value;
   endtask

   task automatic check_all_regs(input string phase);
      reg_data_t rd;
      for (int ch = 0; ch < `NOS_PWM_CHANNELS; ch++) begin
         for (int r = 0; r < 3; r++) begin
            host_read(reg_address(ch, r), rd);
            check_value($sformatf("%s ch%0d reg%0d", phase, ch, r), model[ch][r], rd);
         end
      end
   endtask

   // outputs quiet and the bus holds the host pattern
   task automatic check_idle(input string phase);
      check_value($sformatf("%s ack", phase), 0, ack);
      check_value($sformatf("%s handshake_2", phase), 0, hs2);
      check_value($sformatf("%s pwm_out", phase), 0, pwm_out);
      check_value($sformatf("%s led1", phase), 0, led1);
      check_value($sformatf("%s led2", phase), 32'(!rst), led2);
      check_value($sformatf("%s bus", phase), host_byte, up_data);
      host_byte = ~host_byte;
   endtask

   task automatic count_high(input int ch, input int n, output int highs);
      highs = 0;
      repeat (n) begin
         @(negedge clk);
         if (pwm_out[ch] === 1'b1) begin
            highs++;
         end
      end
   endtask

   task automatic measure_waveform(input int ch, input pwm_count_t period,
                                   input pwm_count_t duty);
      logic [31:0] hl;
      int          win;
      int          run;
      int          edges;
      logic        prev;
      logic        cur;
      string       name;
      name = $sformatf("wave ch%0d p%0d d%0d", ch, period, duty);
      // stopped channel reloads its shadows as soon as enable sets
      write_reg(ch, `REG_CONTROL, 16'd0);
      write_reg(ch, `REG_PERIOD, period);
      write_reg(ch, `REG_DUTY, duty);
      write_reg(ch, `REG_CONTROL, 16'd1);
      hl  = expected_high_low(period, duty, 1'b1);
      win = (period == 0) ? 32 : 3 * int'(period);
      repeat (2 * int'(period) + 4) @(negedge clk);
      prev  = pwm_out[ch];
      run   = 0;
      edges = 0;
      repeat (win) begin
         @(negedge clk);
         cur = pwm_out[ch];
         if (cur !== prev) begin
            // first run is cut by the window start
            if (edges > 0) begin
               check_value($sformatf("%s run level %0d", name, prev),
                           prev ? hl[31:16] : hl[15:0], run);
            end
            edges++;
            run = 1;
         end else begin
            run++;
         end
         prev = cur;
      end
      check_value($sformatf("%s edges", name), (hl[31:16] != 0 && hl[15:0] != 0) ? 6 : 0,
                  edges);
      if (edges == 0) begin
         check_value($sformatf("%s level", name), 32'(hl[31:16] != 0), prev);
      end
   endtask

   // led1 after the nth clock of run time is bit 0 of n / hb_half
   initial begin
      hb_done = 1'b0;
      @(negedge rst);
      for (int n = 1; n <= 8 * hb_half; n++) begin
         @(negedge clk);
         check_value($sformatf("heartbeat cycle %0d", n), (n / hb_half) % 2, led1);
      end
      hb_done = 1'b1;
   end

   initial begin
      pwm_count_t  period;
      pwm_count_t  duty;
      reg_data_t   rd;
      int          highs;
      logic [31:0] hl;
      rst        = 1'b1;
      start      = 1'b0;
      hs1        = 1'b0;
      rw         = 1'b0;
      lfsr       = lfsr_seed;
      // pattern on the bus reads back only if the DUT stays off it
      host_drive = 1'b1;
      host_byte  = 8'ha5;
      for (int ch = 0; ch < `NOS_PWM_CHANNELS; ch++) begin
         for (int r = 0; r < 3; r++) begin
            model[ch][r] = '0;
         end
      end
      repeat (4) begin
         @(negedge clk);
         check_idle("in reset");
      end
      rst = 1'b0;
      repeat (3) begin
         @(negedge clk);
         check_idle("after reset");
      end
      host_drive = 1'b0;

      // random register contents with a whole random byte for control
      for (int round = 0; round < 2; round++) begin
         for (int ch = 0; ch < `NOS_PWM_CHANNELS; ch++) begin
            write_reg(ch, `REG_CONTROL, 16'(rand_bits(8)));
            write_reg(ch, `REG_PERIOD, 16'(rand_bits(16)));
            write_reg(ch, `REG_DUTY, 16'(rand_bits(16)));
         end
         check_all_regs($sformatf("readback round %0d", round));
      end

      // channel 5 and register 7 do not exist
      for (int i = 0; i < 4; i++) begin
         host_write(unmapped[i], 16'(rand_bits(16)));
      end
      for (int i = 0; i < 4; i++) begin
         host_read(unmapped[i], rd);
         check_value($sformatf("unmapped read %02h", unmapped[i]), 0, rd);
      end
      check_all_regs("after unmapped writes");

      // three random runs, then duty 0, duty past period, period 0
      for (int i = 0; i < 6; i++) begin
         period = pwm_count_t'(8 + rand_bits(6) % 33);
         duty   = pwm_count_t'(rand_bits(6) % (period + 5));
         if (i == 3) begin
            duty = '0;
         end
         if (i == 4) begin
            duty = period + pwm_count_t'(rand_bits(2));
         end
         if (i == 5) begin
            period = '0;
         end
         measure_waveform(i % 2, period, duty);
      end

      // half duty run on channel 0 that is then switched off
      write_reg(0, `REG_CONTROL, 16'd0);
      write_reg(0, `REG_PERIOD, 16'd20);
      write_reg(0, `REG_DUTY, 16'd10);
      write_reg(0, `REG_CONTROL, 16'd1);
      repeat (60) @(negedge clk);
      count_high(0, 20, highs);
      hl = expected_high_low(16'd20, 16'd10, 1'b1);
      check_value("running before disable", hl[31:16], highs);
      write_reg(0, `REG_CONTROL, 16'd0);
      // 200 cycles span ten periods of 20
      count_high(0, 200, highs);
      hl = expected_high_low(16'd20, 16'd10, 1'b0);
      check_value("output after disable", 10 * hl[31:16], highs);

      wait (hb_done);
      $display("closing counts: %0d mismatches, %0d handshake timeouts", errors, timeouts);
      if (errors == 0 && timeouts == 0) begin
         $display("TEST OK");
      end else begin
         $display("TEST FAILED");
      end
      $finish;
   end

endmodule

`default_nettype wire

//--- motion_system.f
+incdir+source
source/motion_bus_pkg.sv
source/pwm_pkg.sv
source/up_bus_controller.sv
source/pwm_generator.sv
source/pwm_channel.sv
source/heartbeat_blinker.sv
source/motion_system.sv
tests/motion_system_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# build the motion system testbench with verilator, run it and scan the log
set -o pipefail
cd "$(dirname "$0")" || exit 1
LOG=sim.log
rm -f "$LOG"
verilator --binary --timing --assert -Wno-fatal \
   --top-module motion_system_tb -f motion_system.f -o motion_system_sim \
   && ./obj_dir/motion_system_sim | tee "$LOG" \
   || { echo "verilator build or simulation did not complete"; exit 1; }
grep -q "TEST FAILED" "$LOG" && { echo "simulation reported a failure"; exit 1; }
grep -q "TEST OK" "$LOG" || { echo "no pass line found in $LOG"; exit 1; }
echo "simulation passed"
exit 0
